// ==== design/axi_burst_pkg.sv ====
`default_nettype none

package axi_burst_pkg;

    localparam int axi_beats  = 4;
    localparam int axi_data_w = 64;
    localparam int axi_len_w  = 8;
    localparam int beat_w     = $clog2(axi_beats);

    localparam logic [axi_len_w-1:0] axi_len_value = 8'd3;   // beats minus one

    // write channel FSM
    localparam logic [1:0] ws_idle = 2'b00;
    localparam logic [1:0] ws_aw   = 2'b01;
    localparam logic [1:0] ws_w    = 2'b11;
    localparam logic [1:0] ws_b    = 2'b10;

    // read channel FSM
    localparam logic [1:0] rs_idle = 2'b00;
    localparam logic [1:0] rs_ar   = 2'b01;
    localparam logic [1:0] rs_r    = 2'b11;

endpackage

`default_nettype wire

// ==== design/cache_way_if.sv ====
`timescale 1ns/1ps
`default_nettype none

interface cache_way_if import dcache_cfg_pkg::*; ();

    // controller side
    logic [index_w-1:0] lookup_index;
    logic               wr_en;      // single-cycle strobe
    logic [index_w-1:0] wr_index;
    logic [tag_w-1:0]   wr_tag;     // also the request tag for the compare
    logic [line_w-1:0]  wr_line;
    logic               wr_dirty;
    logic               wr_valid;

    // way side, combinational reads
    logic               hit;
    logic [line_w-1:0]  rd_line;
    logic [tag_w-1:0]   rd_tag;
    logic               rd_dirty;

    modport ctrl (
        output lookup_index, wr_en, wr_index, wr_tag, wr_line, wr_dirty, wr_valid,
        input  hit, rd_line, rd_tag, rd_dirty
    );

    modport way (
        input  lookup_index, wr_en, wr_index, wr_tag, wr_line, wr_dirty, wr_valid,
        output hit, rd_line, rd_tag, rd_dirty
    );

endinterface

`default_nettype wire

// ==== design/dcache_axi_bridge.sv ====
`timescale 1ns/1ps
`default_nettype none

module dcache_axi_bridge import dcache_cfg_pkg::*, axi_burst_pkg::*; (
    input  logic                  clock,
    input  logic                  reset,
    mem_req_if.bridge             mem_if,
    output logic                  aw_valid_o,
    input  logic                  aw_ready_i,
    output logic [addr_w-1:0]     aw_addr_o,
    output logic [axi_len_w-1:0]  aw_len_o,
    output logic                  w_valid_o,
    input  logic                  w_ready_i,
    output logic [axi_data_w-1:0] w_data_o,
    output logic                  w_last_o,
    input  logic                  b_valid_i,
    output logic                  b_ready_o,
    output logic                  ar_valid_o,
    input  logic                  ar_ready_i,
    output logic [addr_w-1:0]     ar_addr_o,
    output logic [axi_len_w-1:0]  ar_len_o,
    input  logic                  r_valid_i,
    output logic                  r_ready_o,
    input  logic [axi_data_w-1:0] r_data_i,
    input  logic                  r_last_i
);

    logic [1:0]        w_state_q, w_state_next;
    logic [1:0]        r_state_q, r_state_next;
    logic [beat_w-1:0] beat_q;
    logic [addr_w-1:0] wb_addr_q;
    logic [addr_w-1:0] rf_addr_q;
    logic [axi_beats-1:0][axi_data_w-1:0] wb_line_q;
    logic [axi_beats-1:0][axi_data_w-1:0] rf_line_q;
    logic              rf_done_q;

    always_comb begin
        w_state_next = w_state_q;
        case (w_state_q)
            ws_idle: if (mem_if.wb_start) w_state_next = ws_aw;
            ws_aw:   if (aw_ready_i) w_state_next = ws_w;
            ws_w:    if (w_ready_i && w_last_o) w_state_next = ws_b;
            default: if (b_valid_i) w_state_next = ws_idle;   // ws_b
        endcase
    end

    always_comb begin
        r_state_next = r_state_q;
        case (r_state_q)
            rs_idle: if (mem_if.rf_start) r_state_next = rs_ar;
            rs_ar:   if (ar_ready_i) r_state_next = rs_r;
            rs_r:    if (r_valid_i && r_last_i) r_state_next = rs_idle;
            default: r_state_next = rs_idle;
        endcase
    end

    always_ff @(posedge clock or negedge reset) begin
        if (!reset) begin
            w_state_q <= ws_idle;
            r_state_q <= rs_idle;
            beat_q    <= '0;
            rf_done_q <= 1'b0;
        end else begin
            w_state_q <= w_state_next;
            r_state_q <= r_state_next;
            if (w_valid_o && w_ready_i) beat_q <= beat_q + beat_w'(1);   // wraps after last
            rf_done_q <= r_ready_o && r_valid_i && r_last_i;
        end
    end

    // latched burst payload
    always_ff @(posedge clock) begin
        if (w_state_q == ws_idle && mem_if.wb_start) begin
            wb_addr_q <= mem_if.wb_addr;
            wb_line_q <= mem_if.wb_line;
        end
        if (r_state_q == rs_idle && mem_if.rf_start) rf_addr_q <= mem_if.rf_addr;
        if (r_ready_o && r_valid_i)
            rf_line_q <= {r_data_i, rf_line_q[axi_beats-1:1]};   // first beat ends lowest
    end

    assign aw_valid_o = (w_state_q == ws_aw);
    assign aw_addr_o  = wb_addr_q;
    assign aw_len_o   = axi_len_value;
    assign w_valid_o  = (w_state_q == ws_w);
    assign w_data_o   = wb_line_q[beat_q];
    assign w_last_o   = w_valid_o && (beat_q == beat_w'(axi_beats - 1));
    assign b_ready_o  = (w_state_q == ws_b);

    assign ar_valid_o = (r_state_q == rs_ar);
    assign ar_addr_o  = rf_addr_q;
    assign ar_len_o   = axi_len_value;
    assign r_ready_o  = (r_state_q == rs_r);

    assign mem_if.wb_done = b_ready_o && b_valid_i;
    assign mem_if.rf_done = rf_done_q;
    assign mem_if.rf_line = rf_line_q;

endmodule

`default_nettype wire

// ==== design/dcache_cfg_pkg.sv ====
`default_nettype none

package dcache_cfg_pkg;

    localparam int num_ways       = 2;    // also works with 4
    localparam int num_sets       = 4;
    localparam int words_per_line = 4;
    localparam int index_w        = 2;
    localparam int tag_w          = 25;
    localparam int line_w         = 256;
    localparam int word_w         = 64;
    localparam int addr_w         = 32;
    localparam int way_w          = $clog2(num_ways);

    // controller states
    localparam logic [2:0] st_idle    = 3'd0;
    localparam logic [2:0] st_lookup  = 3'd1;
    localparam logic [2:0] st_resp    = 3'd2;
    localparam logic [2:0] st_evict   = 3'd3;
    localparam logic [2:0] st_wb_wait = 3'd4;
    localparam logic [2:0] st_refill  = 3'd5;
    localparam logic [2:0] st_rf_wait = 3'd6;

    // byte address as seen on AXI, or split into cache fields
    typedef union packed {
        logic [addr_w-1:0] raw;
        struct packed {
            logic [tag_w-1:0]   tag;
            logic [index_w-1:0] index;
            logic [1:0]         word_sel;
            logic [2:0]         byte_off;
        } f;
    } dcache_addr_u;

endpackage

`default_nettype wire

// ==== design/dcache_ctrl.sv ====
`timescale 1ns/1ps
`default_nettype none

module dcache_ctrl import dcache_cfg_pkg::*; (
    input  logic                  clock,
    input  logic                  reset,
    input  logic                  req_valid_i,
    output logic                  req_ready_o,
    input  logic                  req_write_i,
    input  logic [addr_w-1:0]     req_addr_i,
    input  logic [word_w-1:0]     req_wdata_i,
    input  logic [word_w/8-1:0]   req_wmask_i,
    output logic                  resp_valid_o,
    output logic [word_w-1:0]     resp_rdata_o,
    cache_way_if.ctrl             way_if [num_ways],
    mem_req_if.ctrl               mem_if
);

    logic [2:0]          state_q;
    dcache_addr_u        req_q;
    logic                req_write_q;
    logic [word_w-1:0]   req_wdata_q;
    logic [word_w/8-1:0] req_wmask_q;
    logic [way_w-1:0]    lru_q [num_sets];    // next victim per set
    logic [way_w-1:0]    hit_way_q;
    logic [way_w-1:0]    victim_q;
    logic                resp_valid_q;
    logic [word_w-1:0]   resp_rdata_q;

    logic [num_ways-1:0] hit_vec;
    logic [num_ways-1:0] dirty_vec;
    logic [line_w-1:0]   rd_lines [num_ways];
    logic [tag_w-1:0]    rd_tags  [num_ways];
    logic [way_w-1:0]    hit_way;
    logic [words_per_line-1:0][word_w-1:0] sel_words;
    logic [words_per_line-1:0][word_w-1:0] merged_line;
    dcache_addr_u        rf_line_addr;
    dcache_addr_u        wb_line_addr;
    logic                store_wr;
    logic                install;

    assign store_wr = (state_q == st_resp) && req_write_q;
    assign install  = (state_q == st_rf_wait) && mem_if.rf_done;

    for (genvar w = 0; w < num_ways; w++) begin : g_way
        assign hit_vec[w]   = way_if[w].hit;
        assign dirty_vec[w] = way_if[w].rd_dirty;
        assign rd_lines[w]  = way_if[w].rd_line;
        assign rd_tags[w]   = way_if[w].rd_tag;

        assign way_if[w].lookup_index = req_q.f.index;
        assign way_if[w].wr_index     = req_q.f.index;
        assign way_if[w].wr_tag       = req_q.f.tag;
        assign way_if[w].wr_en        = (store_wr && hit_way_q == way_w'(w)) ||
                                        (install && victim_q == way_w'(w));
        assign way_if[w].wr_line      = install ? mem_if.rf_line : merged_line;
        assign way_if[w].wr_dirty     = !install;   // refills go in clean
        assign way_if[w].wr_valid     = 1'b1;
    end

    always_comb begin
        hit_way = '0;
        for (int w = 0; w < num_ways; w++) begin
            if (hit_vec[w]) hit_way = way_w'(w);
        end
    end

    // byte merge of the store into the hit line
    assign sel_words = rd_lines[hit_way_q];
    always_comb begin
        merged_line = sel_words;
        for (int b = 0; b < word_w / 8; b++) begin
            if (req_wmask_q[b])
                merged_line[req_q.f.word_sel][b*8 +: 8] = req_wdata_q[b*8 +: 8];
        end
    end

    // line aligned addresses for refill and victim
    always_comb begin
        rf_line_addr            = req_q;
        rf_line_addr.f.word_sel = '0;
        rf_line_addr.f.byte_off = '0;
        wb_line_addr            = rf_line_addr;
        wb_line_addr.f.tag      = rd_tags[victim_q];
    end

    always_ff @(posedge clock) begin
        if (req_valid_i && req_ready_o) begin
            req_q.raw   <= req_addr_i;
            req_write_q <= req_write_i;
            req_wdata_q <= req_wdata_i;
            req_wmask_q <= req_wmask_i;
        end
        if (state_q == st_resp) resp_rdata_q <= sel_words[req_q.f.word_sel];
    end

    always_ff @(posedge clock or negedge reset) begin
        if (!reset) begin
            state_q      <= st_idle;
            resp_valid_q <= 1'b0;
            hit_way_q    <= '0;
            victim_q     <= '0;
            for (int s = 0; s < num_sets; s++) lru_q[s] <= '0;
        end else begin
            resp_valid_q <= 1'b0;
            case (state_q)
                st_idle: if (req_valid_i) state_q <= st_lookup;
                st_lookup: begin
                    if (|hit_vec) begin
                        hit_way_q <= hit_way;
                        state_q   <= st_resp;
                    end else begin
                        victim_q <= lru_q[req_q.f.index];
                        state_q  <= dirty_vec[lru_q[req_q.f.index]] ? st_evict : st_refill;
                    end
                end
                st_resp: begin
                    resp_valid_q           <= 1'b1;
                    lru_q[req_q.f.index]   <= hit_way_q + way_w'(1);
                    state_q                <= st_idle;
                end
                st_evict:   state_q <= st_wb_wait;
                st_wb_wait: if (mem_if.wb_done) state_q <= st_refill;
                st_refill:  state_q <= st_rf_wait;
                st_rf_wait: if (mem_if.rf_done) state_q <= st_lookup;   // replay
                default:    state_q <= st_idle;
            endcase
        end
    end

    assign mem_if.wb_start = (state_q == st_evict);
    assign mem_if.wb_addr  = wb_line_addr.raw;
    assign mem_if.wb_line  = rd_lines[victim_q];
    assign mem_if.rf_start = (state_q == st_refill);
    assign mem_if.rf_addr  = rf_line_addr.raw;

    assign req_ready_o  = (state_q == st_idle);
    assign resp_valid_o = resp_valid_q;
    assign resp_rdata_o = resp_rdata_q;

endmodule

`default_nettype wire

// ==== design/dcache_top.sv ====
`timescale 1ns/1ps
`default_nettype none

module dcache_top import dcache_cfg_pkg::*, axi_burst_pkg::*; (
    input  logic                  clock,
    input  logic                  reset,
    input  logic                  req_valid_i,
    output logic                  req_ready_o,
    input  logic                  req_write_i,
    input  logic [addr_w-1:0]     req_addr_i,
    input  logic [word_w-1:0]     req_wdata_i,
    input  logic [word_w/8-1:0]   req_wmask_i,
    output logic                  resp_valid_o,
    output logic [word_w-1:0]     resp_rdata_o,
    output logic                  aw_valid_o,
    input  logic                  aw_ready_i,
    output logic [addr_w-1:0]     aw_addr_o,
    output logic [axi_len_w-1:0]  aw_len_o,
    output logic                  w_valid_o,
    input  logic                  w_ready_i,
    output logic [axi_data_w-1:0] w_data_o,
    output logic                  w_last_o,
    input  logic                  b_valid_i,
    output logic                  b_ready_o,
    output logic                  ar_valid_o,
    input  logic                  ar_ready_i,
    output logic [addr_w-1:0]     ar_addr_o,
    output logic [axi_len_w-1:0]  ar_len_o,
    input  logic                  r_valid_i,
    output logic                  r_ready_o,
    input  logic [axi_data_w-1:0] r_data_i,
    input  logic                  r_last_i
);

    cache_way_if way_bus [num_ways] ();
    mem_req_if   mem_bus ();

    for (genvar w = 0; w < num_ways; w++) begin : g_way
        dcache_way u_way (
            .clock  (clock),
            .reset  (reset),
            .way_if (way_bus[w])
        );
    end

    dcache_ctrl u_ctrl (
        .clock        (clock),
        .reset        (reset),
        .req_valid_i  (req_valid_i),
        .req_ready_o  (req_ready_o),
        .req_write_i  (req_write_i),
        .req_addr_i   (req_addr_i),
        .req_wdata_i  (req_wdata_i),
        .req_wmask_i  (req_wmask_i),
        .resp_valid_o (resp_valid_o),
        .resp_rdata_o (resp_rdata_o),
        .way_if       (way_bus),
        .mem_if       (mem_bus)
    );

    dcache_axi_bridge u_bridge (
        .clock      (clock),
        .reset      (reset),
        .mem_if     (mem_bus),
        .aw_valid_o (aw_valid_o),
        .aw_ready_i (aw_ready_i),
        .aw_addr_o  (aw_addr_o),
        .aw_len_o   (aw_len_o),
        .w_valid_o  (w_valid_o),
        .w_ready_i  (w_ready_i),
        .w_data_o   (w_data_o),
        .w_last_o   (w_last_o),
        .b_valid_i  (b_valid_i),
        .b_ready_o  (b_ready_o),
        .ar_valid_o (ar_valid_o),
        .ar_ready_i (ar_ready_i),
        .ar_addr_o  (ar_addr_o),
        .ar_len_o   (ar_len_o),
        .r_valid_i  (r_valid_i),
        .r_ready_o  (r_ready_o),
        .r_data_i   (r_data_i),
        .r_last_i   (r_last_i)
    );

endmodule

`default_nettype wire

// ==== design/dcache_way.sv ====
`timescale 1ns/1ps
`default_nettype none

module dcache_way import dcache_cfg_pkg::*; (
    input  logic     clock,
    input  logic     reset,
    cache_way_if.way way_if
);

    logic [num_sets-1:0] valid_q;
    logic [num_sets-1:0] dirty_q;
    logic [tag_w-1:0]    tag_q  [num_sets];
    logic [line_w-1:0]   line_q [num_sets];

    // per-set state bits
    always_ff @(posedge clock or negedge reset) begin
        if (!reset) begin
            valid_q <= '0;
            dirty_q <= '0;
        end else if (way_if.wr_en) begin
            valid_q[way_if.wr_index] <= way_if.wr_valid;
            dirty_q[way_if.wr_index] <= way_if.wr_dirty;
        end
    end

    always_ff @(posedge clock) begin
        if (way_if.wr_en) begin
            tag_q[way_if.wr_index]  <= way_if.wr_tag;
            line_q[way_if.wr_index] <= way_if.wr_line;
        end
    end

    // tag compare against the registered request
    assign way_if.hit = valid_q[way_if.lookup_index] &&
                        (tag_q[way_if.lookup_index] == way_if.wr_tag);

    assign way_if.rd_line  = line_q[way_if.lookup_index];
    assign way_if.rd_tag   = tag_q[way_if.lookup_index];
    assign way_if.rd_dirty = valid_q[way_if.lookup_index] & dirty_q[way_if.lookup_index];

endmodule

`default_nettype wire

// ==== design/mem_req_if.sv ====
`timescale 1ns/1ps
`default_nettype none

interface mem_req_if import dcache_cfg_pkg::*; ();

    logic              wb_start;   // write back one line
    logic [addr_w-1:0] wb_addr;
    logic [line_w-1:0] wb_line;
    logic              wb_done;    // after the b response

    logic              rf_start;   // refill one line
    logic [addr_w-1:0] rf_addr;
    logic              rf_done;    // rf_line valid with this strobe
    logic [line_w-1:0] rf_line;

    modport ctrl (
        output wb_start, wb_addr, wb_line, rf_start, rf_addr,
        input  wb_done, rf_done, rf_line
    );

    modport bridge (
        input  wb_start, wb_addr, wb_line, rf_start, rf_addr,
        output wb_done, rf_done, rf_line
    );

endinterface

`default_nettype wire

// ==== dv/dcache_properties.sv ====
`timescale 1ns/1ps
`default_nettype none

module dcache_properties import dcache_cfg_pkg::*, axi_burst_pkg::*; (
    input  logic                  clock,
    input  logic                  reset,
    input  logic                  req_valid_i,
    input  logic                  req_ready_o,
    input  logic                  resp_valid_o,
    input  logic                  aw_valid_o,
    input  logic                  aw_ready_i,
    input  logic [addr_w-1:0]     aw_addr_o,
    input  logic                  w_valid_o,
    input  logic                  w_ready_i,
    input  logic [axi_data_w-1:0] w_data_o,
    input  logic                  w_last_o,
    input  logic                  ar_valid_o,
    input  logic                  ar_ready_i,
    input  logic [addr_w-1:0]     ar_addr_o
);

    logic [beat_w-1:0] w_beat_q;    // w beats accepted in this burst
    logic              busy_q;      // request taken and response still due

    always_ff @(posedge clock or negedge reset) begin
        if (!reset) begin
            w_beat_q <= '0;
            busy_q   <= 1'b0;
        end else begin
            if (w_valid_o && w_ready_i) w_beat_q <= w_beat_q + beat_w'(1);
            if (req_valid_i && req_ready_o) busy_q <= 1'b1;
            else if (resp_valid_o) busy_q <= 1'b0;
        end
    end

    aw_hold: assert property (@(posedge clock) disable iff (!reset)
        aw_valid_o && !aw_ready_i |=> aw_valid_o && $stable(aw_addr_o))
        else $error("aw_valid_o dropped or aw_addr_o changed before aw_ready_i");

    w_hold: assert property (@(posedge clock) disable iff (!reset)
        w_valid_o && !w_ready_i |=> w_valid_o && $stable(w_data_o) && $stable(w_last_o))
        else $error("w_valid_o dropped or the w payload changed before w_ready_i");

    ar_hold: assert property (@(posedge clock) disable iff (!reset)
        ar_valid_o && !ar_ready_i |=> ar_valid_o && $stable(ar_addr_o))
        else $error("ar_valid_o dropped or ar_addr_o changed before ar_ready_i");

    // last flag on the fourth beat and nowhere else
    w_last_beat: assert property (@(posedge clock) disable iff (!reset)
        w_valid_o |-> (w_last_o == (w_beat_q == beat_w'(axi_beats - 1))))
        else $error("w_last_o does not match the fourth w beat");

    ready_while_busy: assert property (@(posedge clock) disable iff (!reset)
        busy_q && !resp_valid_o |-> !req_ready_o)
        else $error("req_ready_o high before the response of the accepted request");

endmodule

bind dcache_top dcache_properties u_dcache_properties (
    .clock        (clock),
    .reset        (reset),
    .req_valid_i  (req_valid_i),
    .req_ready_o  (req_ready_o),
    .resp_valid_o (resp_valid_o),
    .aw_valid_o   (aw_valid_o),
    .aw_ready_i   (aw_ready_i),
    .aw_addr_o    (aw_addr_o),
    .w_valid_o    (w_valid_o),
    .w_ready_i    (w_ready_i),
    .w_data_o     (w_data_o),
    .w_last_o     (w_last_o),
    .ar_valid_o   (ar_valid_o),
    .ar_ready_i   (ar_ready_i),
    .ar_addr_o    (ar_addr_o)
);

`default_nettype wire

// ==== dv/dcache_tb.sv ====
`timescale 1ns/1ps
`default_nettype none

module dcache_tb import dcache_cfg_pkg::*, axi_burst_pkg::*; ();

    localparam int mem_words      = 64;
    localparam int mem_bytes      = mem_words * 8;
    localparam int first_oob_line = mem_words / words_per_line;   // lines above the memory
    localparam int num_random     = 300;
    localparam int num_requests   = 7 + num_random + num_sets * num_ways;
    localparam int cycle_limit    = 200 * num_requests;

    logic                  clock;
    logic                  reset;
    logic                  req_valid_i;
    logic                  req_ready_o;
    logic                  req_write_i;
    logic [addr_w-1:0]     req_addr_i;
    logic [word_w-1:0]     req_wdata_i;
    logic [word_w/8-1:0]   req_wmask_i;
    logic                  resp_valid_o;
    logic [word_w-1:0]     resp_rdata_o;
    logic                  aw_valid_o;
    logic                  aw_ready_i;
    logic [addr_w-1:0]     aw_addr_o;
    logic [axi_len_w-1:0]  aw_len_o;
    logic                  w_valid_o;
    logic                  w_ready_i;
    logic [axi_data_w-1:0] w_data_o;
    logic                  w_last_o;
    logic                  b_valid_i;
    logic                  b_ready_o;
    logic                  ar_valid_o;
    logic                  ar_ready_i;
    logic [addr_w-1:0]     ar_addr_o;
    logic [axi_len_w-1:0]  ar_len_o;
    logic                  r_valid_i;
    logic                  r_ready_o;
    logic [axi_data_w-1:0] r_data_i;
    logic                  r_last_i;

    logic [63:0] mem    [mem_words];    // backing memory behind AXI
    logic [63:0] shadow [mem_words];    // architectural contents
    logic [64:0] expected_q [$];        // bit 64 marks a load
    logic [31:0] rng_q;
    logic [31:0] bp_q;                  // back-pressure stream
    logic [5:0]  wr_base;
    int          wr_beat;
    logic [31:0] rd_addr;
    int          rd_beat;
    logic        rd_active;
    logic        b_pending;
    logic        r_hold;
    int          aw_count, w_count, ar_count;
    logic [31:0] last_aw_addr, last_ar_addr;
    int          cycle_count = 0;

    dcache_top u_dcache_top (.*);

    initial begin
        clock = 1'b0;
        forever #4 clock = ~clock;
    end

    function automatic logic [31:0] lcg_step(input logic [31:0] s);
        return s * 32'd1103515245 + 32'd12345;
    endfunction

    function automatic logic [63:0] merge_bytes(input logic [63:0] old_word,
                                                input logic [63:0] new_word,
                                                input logic [7:0]  mask);
        logic [63:0] result;
        result = old_word;
        for (int b = 0; b < 8; b++) begin
            if (mask[b]) result[b*8 +: 8] = new_word[b*8 +: 8];
        end
        return result;
    endfunction

    // expected load data from the shadow memory
    // words above the memory follow their address
    function automatic logic [63:0] expected_load(input logic [31:0] addr);
        if (addr < 32'(mem_bytes)) return shadow[addr[8:3]];
        return {addr, ~addr};
    endfunction

    function automatic logic [63:0] backing_word(input logic [31:0] addr);
        if (addr < 32'(mem_bytes)) return mem[addr[8:3]];
        return {addr, ~addr};
    endfunction

    task automatic abort_run(input string reason);
        $display("%s", reason);
        $display("Simulation failed");
        $fatal(1, "run stopped at the first error");
    endtask

    task automatic check_value(input string name, input logic [63:0] got,
                               input logic [63:0] exp);
        if (got !== exp)
            abort_run($sformatf("mismatch at %0d ns: %s is %h, expected %h",
                                $time, name, got, exp));
    endtask

    // one request and its response latency in cycles after acceptance
    task automatic send_request(input logic write, input logic [31:0] addr,
                                input logic [63:0] wdata, input logic [7:0] wmask,
                                output int resp_cycle);
        int         edges;
        logic [5:0] idx;
        edges       = 0;
        idx         = addr[8:3];
        req_valid_i = 1'b1;
        req_write_i = write;
        req_addr_i  = addr;
        req_wdata_i = wdata;
        req_wmask_i = wmask;
        do @(posedge clock); while (!req_ready_o);
        if (write) begin
            expected_q.push_back({1'b0, 64'd0});
            shadow[idx] = merge_bytes(shadow[idx], wdata, wmask);
        end else begin
            expected_q.push_back({1'b1, expected_load(addr)});
        end
        #1 req_valid_i = 1'b0;
        do begin
            @(posedge clock);
            edges++;
        end while (!resp_valid_o);
        resp_cycle = edges - 1;
        #1;
    endtask

    // AXI memory model that samples at the edge and drives 1 ns later
    always begin
        @(posedge clock);
        if (aw_valid_o && aw_ready_i) begin
            if (aw_addr_o[4:0] != 5'd0 || aw_addr_o >= 32'(mem_bytes))
                abort_run("write-back burst address is unaligned or outside the memory");
            check_value("aw_len_o", 64'(aw_len_o), 64'(axi_len_value));
            wr_base      = aw_addr_o[8:3];
            wr_beat      = 0;
            last_aw_addr = aw_addr_o;
            aw_count++;
        end
        if (w_valid_o && w_ready_i) begin
            check_value("w_last_o", 64'(w_last_o), 64'(wr_beat == axi_beats - 1));
            check_value("w_data_o", w_data_o, shadow[wr_base + 6'(wr_beat)]);
            mem[wr_base + 6'(wr_beat)] = w_data_o;
            if (w_last_o) b_pending = 1'b1;
            wr_beat++;
            w_count++;
        end
        if (b_valid_i && b_ready_o) b_pending = 1'b0;
        if (ar_valid_o && ar_ready_i) begin
            if (ar_addr_o[4:0] != 5'd0) abort_run("refill burst address is not line aligned");
            check_value("ar_len_o", 64'(ar_len_o), 64'(axi_len_value));
            rd_addr      = ar_addr_o;
            rd_beat      = 0;
            rd_active    = 1'b1;
            last_ar_addr = ar_addr_o;
            ar_count++;
        end
        if (r_valid_i && r_ready_o) begin
            rd_beat++;
            if (r_last_i) rd_active = 1'b0;
        end
        r_hold = r_valid_i && !r_ready_o;    // beat still owed
        #1;
        bp_q       = lcg_step(bp_q);
        aw_ready_i = (bp_q[31:30] != 2'b00);
        w_ready_i  = (bp_q[29:28] != 2'b00);
        ar_ready_i = (bp_q[27:26] != 2'b00);
        b_valid_i  = b_pending;
        if (!r_hold) begin
            r_valid_i = rd_active && (bp_q[25:24] != 2'b00);
            r_data_i  = backing_word(rd_addr + 32'(rd_beat * 8));
            r_last_i  = r_valid_i && (rd_beat == axi_beats - 1);
        end
    end

    // compare process for load responses
    always @(posedge clock) begin
        logic [64:0] entry;
        if (reset && resp_valid_o) begin
            if (expected_q.size() == 0) abort_run("response pulse without a pending request");
            entry = expected_q.pop_front();
            if (entry[64]) check_value("resp_rdata_o", resp_rdata_o, entry[63:0]);
        end
    end

    always @(posedge clock) begin
        cycle_count++;
        if (cycle_count > cycle_limit)
            abort_run($sformatf("timeout: run still busy after %0d cycles", cycle_limit));
    end

    initial begin
        int          lat;
        int          aw_before, w_before, ar_before;
        logic [31:0] addr;
        logic [31:0] hi;
        logic [63:0] data;
        reset       = 1'b0;
        req_valid_i = 1'b0;
        req_write_i = 1'b0;
        req_addr_i  = '0;
        req_wdata_i = '0;
        req_wmask_i = '0;
        aw_ready_i  = 1'b0;
        w_ready_i   = 1'b0;
        b_valid_i   = 1'b0;
        ar_ready_i  = 1'b0;
        r_valid_i   = 1'b0;
        r_data_i    = '0;
        r_last_i    = 1'b0;
        rd_addr     = '0;
        rd_beat     = 0;
        rd_active   = 1'b0;
        b_pending   = 1'b0;
        wr_base     = '0;
        wr_beat     = 0;
        aw_count    = 0;
        w_count     = 0;
        ar_count    = 0;
        rng_q       = 32'h5564;
        bp_q        = 32'h5564;
        for (int i = 0; i < mem_words; i++) begin
            rng_q     = lcg_step(rng_q);
            hi        = rng_q;
            rng_q     = lcg_step(rng_q);
            mem[i]    = {hi, rng_q};
            shadow[i] = mem[i];
        end
        repeat (5) @(posedge clock);
        #1 reset = 1'b1;
        check_value("req_ready_o", 64'(req_ready_o), 64'd1);
        check_value("idle valids", 64'({resp_valid_o, aw_valid_o, w_valid_o,
                                        ar_valid_o, b_ready_o, r_ready_o}), 64'd0);

        // cold load with one aligned refill
        ar_before = ar_count;
        send_request(1'b0, 32'h08, 64'd0, 8'd0, lat);
        check_value("ar bursts", 64'(ar_count - ar_before), 64'd1);
        check_value("ar_addr_o", 64'(last_ar_addr), 64'h0);

        // same line again with no bus traffic and hit timing
        aw_before = aw_count;
        ar_before = ar_count;
        send_request(1'b0, 32'h18, 64'd0, 8'd0, lat);
        check_value("bursts on hit", 64'(aw_count - aw_before + ar_count - ar_before), 64'd0);
        check_value("hit latency", 64'(lat), 64'd2);

        // partial store then load of the same word
        send_request(1'b1, 32'h28, 64'h1122_3344_5566_7788, 8'b0011_0100, lat);
        send_request(1'b0, 32'h28, 64'd0, 8'd0, lat);

        // three lines in set 2 with the first one dirty
        aw_before = aw_count;
        w_before  = w_count;
        send_request(1'b1, 32'h48, 64'hcafe_f00d_dead_beef, 8'hff, lat);
        send_request(1'b0, 32'hc0, 64'd0, 8'd0, lat);
        send_request(1'b0, 32'h140, 64'd0, 8'd0, lat);
        check_value("aw bursts", 64'(aw_count - aw_before), 64'd1);
        check_value("aw_addr_o", 64'(last_aw_addr), 64'h40);
        check_value("w beats", 64'(w_count - w_before), 64'(axi_beats));

        for (int n = 0; n < num_random; n++) begin
            rng_q = lcg_step(rng_q);
            addr  = {23'd0, rng_q[29:24], 3'd0};
            hi    = rng_q;
            rng_q = lcg_step(rng_q);
            data  = {rng_q, hi ^ 32'h0f0f_0f0f};
            send_request(hi[31], addr, data, hi[23:16], lat);
        end

        // conflict loads above the memory push every dirty line out
        for (int s = 0; s < num_sets; s++) begin
            for (int t = 0; t < num_ways; t++) begin
                addr = 32'((first_oob_line + t * num_sets + s) * 32);
                send_request(1'b0, addr, 64'd0, 8'd0, lat);
            end
        end
        for (int i = 0; i < mem_words; i++)
            check_value($sformatf("mem[%0d]", i), mem[i], shadow[i]);

        $display("Simulation passed");
        $finish;
    end

endmodule

`default_nettype wire

// ==== list.f ====
design/dcache_cfg_pkg.sv
design/axi_burst_pkg.sv
design/cache_way_if.sv
design/mem_req_if.sv
design/dcache_way.sv
design/dcache_ctrl.sv
design/dcache_axi_bridge.sv
design/dcache_top.sv
dv/dcache_properties.sv
dv/dcache_tb.sv

// ==== run.sh ====
#!/usr/bin/env bash
# build the data cache testbench with Verilator, run it, judge the log
cd "$(dirname "$0")" && rm -f sim.log && \
verilator --binary --timing --assert --top-module dcache_tb -f list.f -o dcache_sim && \
{ ./obj_dir/dcache_sim > sim.log 2>&1 || true; } && cat sim.log && \
grep -q "Simulation passed" sim.log && echo "run ok" || { echo "run failed, see sim.log"; exit 1; }
